// ==== Bender.yml ====
package:
  name: periph_board_mgmt

sources:
  - logic/periph_map_pkg.sv
  - logic/periph_timing_pkg.sv
  - logic/sft_driver.sv
  - logic/fan_tach.sv
  - logic/tick_timers.sv
  - logic/periph_regs.sv
  - logic/periph_top.sv
  - target: simulation
    files:
      - verification/periph_assert.sv
      - verification/periph_tb.sv

// ==== files.f ====
logic/periph_map_pkg.sv
logic/periph_timing_pkg.sv
logic/sft_driver.sv
logic/fan_tach.sv
logic/tick_timers.sv
logic/periph_regs.sv
logic/periph_top.sv
verification/periph_assert.sv
verification/periph_tb.sv

// ==== logic/fan_tach.sv ====
`timescale 1ns/1ns
`default_nettype none

module fan_tach (
	input  logic                                CLK_I,
	input  logic                                RST_I,
	input  logic                                fan_in,
	input  logic                                sec_tick,
	output logic [periph_timing_pkg::SEC_CNT_W-1:0] fan_cnt
);
	import periph_timing_pkg::*;

	logic [1:0]           fan_sync;
	logic                 fan_d;    // edge reference
	logic                 fan_fall;
	logic [SEC_CNT_W-1:0] run_cnt;

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			fan_sync <= '0;
			fan_d    <= 1'b0;
		end else begin
			fan_sync <= {fan_sync[0], fan_in};
			fan_d    <= fan_sync[1];
		end
	end

	assign fan_fall = fan_d & ~fan_sync[1];

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			run_cnt <= '0;
			fan_cnt <= '0;
		end else if (sec_tick) begin
			fan_cnt <= run_cnt + SEC_CNT_W'(fan_fall); // window closes
			run_cnt <= '0;
		end else if (fan_fall) begin
			run_cnt <= run_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/periph_map_pkg.sv ====
`default_nettype none

package periph_map_pkg;

	localparam int ADR_W = 6;
	localparam int DAT_W = 32;

	// word addresses
	localparam logic [ADR_W-1:0] ADR_PWM  = 6'd2;
	localparam logic [ADR_W-1:0] ADR_WDG  = 6'd3;
	localparam logic [ADR_W-1:0] ADR_SFT  = 6'd4;
	localparam logic [ADR_W-1:0] ADR_FAN0 = 6'd5;
	localparam logic [ADR_W-1:0] ADR_FAN1 = 6'd6;
	localparam logic [ADR_W-1:0] ADR_TIME = 6'd7;
	localparam logic [ADR_W-1:0] ADR_GPIO = 6'd8;
	localparam logic [ADR_W-1:0] ADR_SFTB = 6'd9;

	localparam logic [15:0] GPIO_RST = 16'h8800; // video oe_n lines idle high

	// shift channel word fields
	localparam int SFT_OE_BIT   = 2;
	localparam int SFT_DONE_BIT = 3;
	localparam int SFT_DIN_LSB  = 8;

	typedef enum logic [1:0] {
		SFT_RESET = 2'd0, // mr_n low pulse
		SFT_SHIFT = 2'd1, // 8 bits, msb first
		SFT_LATCH = 2'd2, // stcp pulse
		SFT_OE    = 2'd3  // oe from data bit 2
	} sft_cmd_e;

endpackage

`default_nettype wire

// ==== logic/periph_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module periph_regs (
	input  logic                                   CLK_I,
	input  logic                                   RST_I,
	input  logic                                   wb_stb,
	input  logic                                   wb_we,
	input  logic [periph_map_pkg::ADR_W-1:0]       wb_adr,
	input  logic [periph_map_pkg::DAT_W-1:0]       wb_dat_i,
	input  logic [periph_map_pkg::DAT_W-1:0]       tim_status,
	input  logic [periph_timing_pkg::SEC_CNT_W-1:0] fan0_cnt,
	input  logic [periph_timing_pkg::SEC_CNT_W-1:0] fan1_cnt,
	input  logic                                   sft_done,
	input  logic                                   sft_oe_n,
	input  logic                                   sftb_done,
	input  logic                                   sftb_oe_n,
	input  logic [15:0]                            gpio_in,
	output logic                                   wb_ack,
	output logic [periph_map_pkg::DAT_W-1:0]       wb_dat_o,
	output logic                                   sft_wr,
	output logic                                   sftb_wr,
	output logic                                   time_wr,
	output logic                                   pwm,
	output logic                                   watch_dog,
	output logic [15:0]                            gpio_out
);
	import periph_map_pkg::*;
	import periph_timing_pkg::*;

	logic             acc;      // access accepted this cycle
	logic             wr_acc;
	logic             pwm_wr, wdg_wr, gpio_wr;
	logic [ADR_W-1:0] rd_adr;
	logic [PWM_W-1:0] pwm_duty, pwm_cnt;
	logic             wdg_en;
	logic [WDG_W-1:0] wdg_cnt;
	logic             sft_done_r, sftb_done_r;
	logic [15:0]      gin_meta, gin_sync;

	// ------------------------------
	// bus handshake
	// ------------------------------
	assign acc     = wb_stb & ~wb_ack;
	assign wr_acc  = acc & wb_we;
	assign pwm_wr  = wr_acc && (wb_adr == ADR_PWM);
	assign wdg_wr  = wr_acc && (wb_adr == ADR_WDG);
	assign sft_wr  = wr_acc && (wb_adr == ADR_SFT);
	assign time_wr = wr_acc && (wb_adr == ADR_TIME);
	assign gpio_wr = wr_acc && (wb_adr == ADR_GPIO);
	assign sftb_wr = wr_acc && (wb_adr == ADR_SFTB);

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			wb_ack <= 1'b0;
			rd_adr <= '0;
		end else begin
			wb_ack <= acc;
			if (acc && !wb_we)
				rd_adr <= wb_adr; // selects the data shown with ack
		end
	end

	// ------------------------------
	// pwm, watchdog, gpio
	// ------------------------------
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			pwm_duty <= '0;
			pwm_cnt  <= '0;
			wdg_en   <= 1'b0;
			wdg_cnt  <= '0;
			gpio_out <= GPIO_RST;
		end else begin
			pwm_cnt <= pwm_cnt + 1'b1; // free running
			if (pwm_wr)
				pwm_duty <= wb_dat_i[PWM_W-1:0];
			if (wdg_wr)
				wdg_en <= wb_dat_i[0];
			if (wdg_wr && (wdg_en || wb_dat_i[0]))
				wdg_cnt <= wb_dat_i[WDG_W:1]; // refresh
			else if (|wdg_cnt)
				wdg_cnt <= wdg_cnt - 1'b1;
			if (gpio_wr)
				gpio_out <= wb_dat_i[15:0];
		end
	end

	assign pwm       = (pwm_cnt < pwm_duty);
	assign watch_dog = wdg_en && (wdg_cnt == WDG_W'(1) || wdg_cnt == WDG_W'(2));

	always_ff @(posedge CLK_I) begin
		gin_meta <= gpio_in;
		gin_sync <= gin_meta;
	end

	// sticky shift done, cleared by any write to the channel
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			sft_done_r  <= 1'b0;
			sftb_done_r <= 1'b0;
		end else begin
			if (sft_wr)
				sft_done_r <= 1'b0;
			else if (sft_done)
				sft_done_r <= 1'b1;
			if (sftb_wr)
				sftb_done_r <= 1'b0;
			else if (sftb_done)
				sftb_done_r <= 1'b1;
		end
	end

	// ------------------------------
	// read mux
	// ------------------------------
	always_comb begin
		wb_dat_o = '0; // unmapped reads
		case (rd_adr)
			ADR_PWM:  wb_dat_o[PWM_W-1:0] = pwm_duty;
			ADR_WDG:  wb_dat_o[WDG_W:0] = {wdg_cnt, wdg_en};
			ADR_SFT: begin
				wb_dat_o[SFT_DONE_BIT] = sft_done_r;
				wb_dat_o[SFT_OE_BIT]   = sft_oe_n;
			end
			ADR_SFTB: begin
				wb_dat_o[SFT_DONE_BIT] = sftb_done_r;
				wb_dat_o[SFT_OE_BIT]   = sftb_oe_n;
			end
			ADR_FAN0: wb_dat_o[SEC_CNT_W-1:0] = fan0_cnt;
			ADR_FAN1: wb_dat_o[SEC_CNT_W-1:0] = fan1_cnt;
			ADR_TIME: wb_dat_o = tim_status;
			ADR_GPIO: wb_dat_o = {gin_sync, gpio_out};
			default:  wb_dat_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/periph_timing_pkg.sv ====
`default_nettype none

package periph_timing_pkg;

	localparam int TICKS_PER_SEC_DEF = 50_000_000; // 50 MHz system clock
	localparam int SFT_DIV_DEF       = 4;

	// counter widths
	localparam int SEC_CNT_W = 27; // also holds a full second of fan edges
	localparam int TIM_W     = 6;
	localparam int PWM_W     = 10;
	localparam int WDG_W     = 26;

endpackage

`default_nettype wire

// ==== logic/periph_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module periph_top #(
	parameter int TICKS_PER_SEC = periph_timing_pkg::TICKS_PER_SEC_DEF,
	parameter int SFT_DIV       = periph_timing_pkg::SFT_DIV_DEF
) (
	input  logic                             CLK_I,
	input  logic                             RST_I,
	input  logic                             wb_stb,
	input  logic                             wb_we,
	input  logic [periph_map_pkg::ADR_W-1:0] wb_adr,
	input  logic [periph_map_pkg::DAT_W-1:0] wb_dat_i,
	output logic                             wb_ack,
	output logic [periph_map_pkg::DAT_W-1:0] wb_dat_o,
	input  logic                             fan_in0,
	input  logic                             fan_in1,
	input  logic [15:0]                      gpio_in,
	output logic                             pwm,
	output logic                             watch_dog,
	output logic                             time0_int,
	output logic                             time1_int,
	output logic [15:0]                      gpio_out,
	output logic                             sft_shcp,
	output logic                             sft_ds,
	output logic                             sft_stcp,
	output logic                             sft_mr_n,
	output logic                             sft_oe_n,
	output logic                             sftb_shcp,
	output logic                             sftb_ds,
	output logic                             sftb_stcp,
	output logic                             sftb_mr_n,
	output logic                             sftb_oe_n
);
	import periph_map_pkg::*;
	import periph_timing_pkg::*;

	logic                 sft_wr, sftb_wr, time_wr;
	logic                 sft_done, sftb_done;
	logic                 sec_tick;
	logic [DAT_W-1:0]     tim_status;
	logic [SEC_CNT_W-1:0] fan0_cnt, fan1_cnt;
	sft_cmd_e             sft_cmd;   // shared by both chains

	assign sft_cmd = sft_cmd_e'(wb_dat_i[1:0]);

	periph_regs u_regs (
		.CLK_I, .RST_I, .wb_stb, .wb_we, .wb_adr, .wb_dat_i, .tim_status,
		.fan0_cnt, .fan1_cnt, .sft_done, .sft_oe_n, .sftb_done, .sftb_oe_n,
		.gpio_in, .wb_ack, .wb_dat_o, .sft_wr, .sftb_wr, .time_wr, .pwm,
		.watch_dog, .gpio_out
	);

	tick_timers #(.TICKS_PER_SEC(TICKS_PER_SEC)) u_timers (
		.CLK_I, .RST_I, .time_wr, .wr_data(wb_dat_i), .sec_tick, .tim_status,
		.time0_int, .time1_int
	);

	fan_tach u_fan0 (.CLK_I, .RST_I, .fan_in(fan_in0), .sec_tick, .fan_cnt(fan0_cnt));
	fan_tach u_fan1 (.CLK_I, .RST_I, .fan_in(fan_in1), .sec_tick, .fan_cnt(fan1_cnt));

	sft_driver #(.SFT_DIV(SFT_DIV)) u_sft_a (
		.CLK_I, .RST_I, .cmd_vld(sft_wr), .cmd(sft_cmd), .cmd_oe(wb_dat_i[SFT_OE_BIT]),
		.din(wb_dat_i[SFT_DIN_LSB +: 8]), .done(sft_done), .sft_shcp, .sft_ds,
		.sft_stcp, .sft_mr_n, .sft_oe_n
	);

	sft_driver #(.SFT_DIV(SFT_DIV)) u_sft_b (
		.CLK_I, .RST_I, .cmd_vld(sftb_wr), .cmd(sft_cmd), .cmd_oe(wb_dat_i[SFT_OE_BIT]),
		.din(wb_dat_i[SFT_DIN_LSB +: 8]), .done(sftb_done), .sft_shcp(sftb_shcp),
		.sft_ds(sftb_ds), .sft_stcp(sftb_stcp), .sft_mr_n(sftb_mr_n), .sft_oe_n(sftb_oe_n)
	);

endmodule

`default_nettype wire

// ==== logic/sft_driver.sv ====
`timescale 1ns/1ns
`default_nettype none

module sft_driver #(
	parameter int SFT_DIV = periph_timing_pkg::SFT_DIV_DEF
) (
	input  logic                    CLK_I,
	input  logic                    RST_I,
	input  logic                    cmd_vld,
	input  periph_map_pkg::sft_cmd_e cmd,
	input  logic                    cmd_oe,
	input  logic [7:0]              din,
	output logic                    done,
	output logic                    sft_shcp,
	output logic                    sft_ds,
	output logic                    sft_stcp,
	output logic                    sft_mr_n,
	output logic                    sft_oe_n
);
	import periph_map_pkg::*;

	localparam int DIV_W = $clog2(SFT_DIV + 1);

	typedef enum logic [1:0] {ST_IDLE, ST_MR, ST_SHIFT, ST_LATCH} state_e;

	state_e           state;
	logic [DIV_W-1:0] div_cnt;
	logic [3:0]       ph_cnt;  // half period index
	logic [7:0]       sreg;
	logic             half_end;

	assign half_end = (div_cnt == DIV_W'(SFT_DIV - 1));

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			state    <= ST_IDLE;
			div_cnt  <= '0;
			ph_cnt   <= '0;
			done     <= 1'b0;
			sft_oe_n <= 1'b1;
		end else begin
			done <= 1'b0;
			if (state == ST_IDLE) begin
				if (cmd_vld) begin
					div_cnt <= '0;
					ph_cnt  <= '0;
					case (cmd)
						SFT_RESET: state <= ST_MR;
						SFT_SHIFT: state <= ST_SHIFT;
						SFT_LATCH: state <= ST_LATCH;
						default: begin
							sft_oe_n <= ~cmd_oe; // finishes at once
							done     <= 1'b1;
						end
					endcase
				end
			end else if (half_end) begin
				div_cnt <= '0;
				ph_cnt  <= ph_cnt + 4'd1;
				if (state != ST_SHIFT || ph_cnt == 4'd15) begin
					state <= ST_IDLE;
					done  <= 1'b1;
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// data byte, next bit always at the top
	always_ff @(posedge CLK_I) begin
		if (state == ST_IDLE && cmd_vld && cmd == SFT_SHIFT)
			sreg <= din;
		else if (state == ST_SHIFT && half_end && ph_cnt[0])
			sreg <= {sreg[6:0], 1'b0};
	end

	assign sft_ds   = sreg[7];
	assign sft_shcp = (state == ST_SHIFT) && ph_cnt[0]; // high in odd halves
	assign sft_stcp = (state == ST_LATCH);
	assign sft_mr_n = (state != ST_MR);

endmodule

`default_nettype wire

// ==== logic/tick_timers.sv ====
`timescale 1ns/1ns
`default_nettype none

module tick_timers #(
	parameter int TICKS_PER_SEC = periph_timing_pkg::TICKS_PER_SEC_DEF
) (
	input  logic        CLK_I,
	input  logic        RST_I,
	input  logic        time_wr,
	input  logic [31:0] wr_data,
	output logic        sec_tick,
	output logic [31:0] tim_status,
	output logic        time0_int,
	output logic        time1_int
);
	import periph_timing_pkg::*;

	logic [SEC_CNT_W-1:0] tick_cnt;
	logic [1:0]           tim_int;

	// ------------------------------
	// one second base
	// ------------------------------
	assign sec_tick = (tick_cnt == SEC_CNT_W'(TICKS_PER_SEC - 1));

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			tick_cnt <= '0;
		else if (sec_tick)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	// ------------------------------
	// countdown channels
	// ------------------------------
	for (genvar i = 0; i < 2; i++) begin : g_ch
		logic [TIM_W-1:0] sec_cnt;
		logic [TIM_W-1:0] sec_prev; // detects the 1 -> 0 step
		logic             tim_done;
		logic             tim_mask;

		always_ff @(posedge CLK_I or posedge RST_I) begin
			if (RST_I) begin
				sec_cnt  <= '0;
				sec_prev <= '0;
				tim_done <= 1'b0;
				tim_mask <= 1'b1;  // masked out of reset
			end else begin
				sec_prev <= sec_cnt;
				if (time_wr && wr_data[16*i])
					sec_cnt <= wr_data[16*i+2 +: TIM_W];
				else if (sec_tick && |sec_cnt)
					sec_cnt <= sec_cnt - 1'b1;
				if (time_wr)
					tim_mask <= wr_data[16*i+1];
				if (sec_cnt == '0 && sec_prev == TIM_W'(1))
					tim_done <= 1'b1;
				else if (time_wr && wr_data[16*i+8])
					tim_done <= 1'b0;
			end
		end

		assign tim_int[i] = tim_done & ~tim_mask;
		assign tim_status[16*i +: 16] = {7'b0, tim_done, sec_cnt, tim_mask, 1'b0};
	end

	assign time0_int = tim_int[0];
	assign time1_int = tim_int[1];

endmodule

`default_nettype wire

// ==== verification/periph_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module periph_assert (
	input logic                             CLK_I,
	input logic                             RST_I,
	input logic                             wb_stb,
	input logic                             wb_we,
	input logic                             wb_ack,
	input logic [periph_map_pkg::ADR_W-1:0] wb_adr,
	input logic [periph_map_pkg::DAT_W-1:0] wb_dat_i,
	input logic                             watch_dog,
	input logic [1:0]                       shcp,
	input logic [1:0]                       stcp
);
	import periph_map_pkg::*;

	int   fail_cnt = 0;
	logic wdg_on;  // enable bit as last written over the bus

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			wdg_on <= 1'b0;
		else if (wb_stb && !wb_ack && wb_we && wb_adr == ADR_WDG)
			wdg_on <= wb_dat_i[0];
	end

	ack_one_cycle: assert property (@(posedge CLK_I) disable iff (RST_I) wb_ack |=> !wb_ack)
	else begin
		$error("ack high for two cycles");
		fail_cnt++;
	end

	ack_after_stb: assert property (@(posedge CLK_I) disable iff (RST_I) wb_ack |-> $past(wb_stb))
	else begin
		$error("ack without a preceding stb");
		fail_cnt++;
	end

	wdg_quiet: assert property (@(posedge CLK_I) disable iff (RST_I) !wdg_on |-> !watch_dog)
	else begin
		$error("watch_dog high while the watchdog is disabled");
		fail_cnt++;
	end

	// both chains, shift and storage clock exclusive
	clk_excl: assert property (@(posedge CLK_I) disable iff (RST_I) (shcp & stcp) == 2'b00)
	else begin
		$error("shcp and stcp high together");
		fail_cnt++;
	end

endmodule

bind periph_top periph_assert u_assert (
	.CLK_I, .RST_I, .wb_stb, .wb_we, .wb_ack, .wb_adr, .wb_dat_i, .watch_dog,
	.shcp({sftb_shcp, sft_shcp}), .stcp({sftb_stcp, sft_stcp})
);

`default_nettype wire

// ==== verification/periph_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module periph_tb;
	import periph_map_pkg::*;

	localparam int TICKS = 200;

	logic             CLK_I, RST_I;
	logic             wb_stb, wb_we, wb_ack;
	logic [ADR_W-1:0] wb_adr;
	logic [31:0]      wb_dat_i, wb_dat_o;
	logic             fan_in0, fan_in1, pwm, watch_dog, time0_int, time1_int;
	logic [15:0]      gpio_in, gpio_out;
	logic [1:0]       shcp, ds, stcp, mr_n, oe_n;  // chain a in bit 0
	logic [1:0]       shcp_q = 2'b00;
	logic [1:0]       stcp_q = 2'b00;
	logic [1:0]       mr_n_q = 2'b11;
	logic [7:0]       bits_seen [2];
	int               bit_cnt [2] = '{0, 0};
	int               stcp_cnt [2] = '{0, 0};
	int               mr_cnt [2] = '{0, 0};
	int               err_cnt = 0;
	int               check_cnt = 0;
	int               test_cnt = 0;
	bit               fan_run = 1'b0;
	int               fan_ph0 = 0;
	int               fan_ph1 = 0;

	periph_top #(.TICKS_PER_SEC(TICKS), .SFT_DIV(3)) u_periph_top (
		.CLK_I, .RST_I, .wb_stb, .wb_we, .wb_adr, .wb_dat_i, .wb_ack, .wb_dat_o,
		.fan_in0, .fan_in1, .gpio_in, .pwm, .watch_dog, .time0_int, .time1_int, .gpio_out,
		.sft_shcp(shcp[0]), .sft_ds(ds[0]), .sft_stcp(stcp[0]), .sft_mr_n(mr_n[0]),
		.sft_oe_n(oe_n[0]), .sftb_shcp(shcp[1]), .sftb_ds(ds[1]), .sftb_stcp(stcp[1]),
		.sftb_mr_n(mr_n[1]), .sftb_oe_n(oe_n[1])
	);

	initial begin
		CLK_I = 1'b0;
		forever #10 CLK_I = ~CLK_I;
	end

	// ------------------------------
	// pin monitors and fan stimulus
	// ------------------------------
	always @(negedge CLK_I) begin
		for (int c = 0; c < 2; c++) begin
			if (shcp[c] && !shcp_q[c]) begin
				bits_seen[c] = {bits_seen[c][6:0], ds[c]}; // msb arrives first
				bit_cnt[c]++;
			end
			if (stcp[c] && !stcp_q[c])
				stcp_cnt[c]++;
			if (!mr_n[c] && mr_n_q[c])
				mr_cnt[c]++;
		end
		shcp_q = shcp;
		stcp_q = stcp;
		mr_n_q = mr_n;
	end

	always @(negedge CLK_I) begin
		if (fan_run) begin
			fan_ph0 = (fan_ph0 + 1) % 10;
			fan_ph1 = (fan_ph1 + 1) % 25;
			fan_in0 = (fan_ph0 < 5);
			fan_in1 = (fan_ph1 < 13);  // 25 cycle period, uneven halves
		end
	end

	// ------------------------------
	// bus and check helpers
	// ------------------------------
	task automatic bus_cycle(input logic we, input logic [ADR_W-1:0] adr,
			input logic [31:0] wdat, output logic [31:0] rdat);
		int waited;
		waited = 0;
		@(negedge CLK_I);
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_i = wdat;
		do begin
			@(negedge CLK_I);
			waited++;
		end while (!wb_ack && waited < 16);
		if (!wb_ack) begin
			$display("timeout: no ack for the access to address %0d", adr);
			err_cnt++;
		end
		rdat   = wb_dat_o;  // valid while ack is high
		wb_stb = 1'b0;
	endtask

	task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [31:0] wdat);
		logic [31:0] unused;
		bus_cycle(1'b1, adr, wdat, unused);
	endtask

	task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [31:0] rdat);
		bus_cycle(1'b0, adr, 32'h0, rdat);
	endtask

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		check_cnt++;
		assert (got === exp)
		else begin
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_true(input string what, input logic cond);
		check_cnt++;
		assert (cond === 1'b1)
		else begin
			$display("[ERROR] %0t: %s", $time, what);
			err_cnt++;
		end
	endtask

	task automatic end_test(input string name, input int err_start);
		test_cnt++;
		$display("test %s finished with %0d errors", name, err_cnt - err_start);
	endtask

	// write a shift command, then poll the sticky done bit
	task automatic run_shift_cmd(input logic [ADR_W-1:0] adr, input logic [31:0] word);
		logic [31:0] rd;
		int          polls;
		rd    = '0;
		polls = 0;
		wb_write(adr, word);
		while (!rd[3] && polls < 40) begin
			wb_read(adr, rd);
			polls++;
		end
		if (!rd[3]) begin
			$display("timeout: shift command %0d at address %0d never finished", word[1:0], adr);
			err_cnt++;
		end
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------
	task automatic test_reset_regs();
		int          e0;
		logic [31:0] val, rd;
		e0 = err_cnt;
		check_eq("wb_ack", wb_ack, 0);
		check_eq("pwm, watch_dog, ints, shcp, stcp",
			{pwm, watch_dog, time0_int, time1_int, shcp, stcp}, 0);
		check_eq("mr_n and oe_n", {mr_n, oe_n}, 4'hf);
		check_eq("gpio_out", gpio_out, 16'h8800);
		val = $urandom;
		wb_write(ADR_GPIO, val);
		wb_read(ADR_GPIO, rd);
		check_eq("gpio read", rd, {gpio_in, val[15:0]});
		check_eq("gpio_out after write", gpio_out, val[15:0]);
		wb_read(6'd0, rd);
		check_eq("unmapped read at 0", rd, 0);
		wb_read(6'd63, rd);
		check_eq("unmapped read at 63", rd, 0);
		end_test("reset and readback", e0);
	endtask

	task automatic test_pwm();
		int         e0, high_cnt;
		logic [9:0] duty [4];
		e0   = err_cnt;
		duty = '{10'd0, 10'd1023, 10'($urandom), 10'($urandom)};
		foreach (duty[i]) begin
			wb_write(ADR_PWM, duty[i]);
			high_cnt = 0;
			repeat (1024) begin  // one full counter period
				@(negedge CLK_I);
				high_cnt += pwm;
			end
			check_eq("pwm high cycles", high_cnt, duty[i]);
		end
		end_test("pwm", e0);
	endtask

	task automatic test_watchdog();
		int   e0, waited;
		logic fired;
		e0    = err_cnt;
		fired = 1'b0;
		wb_write(ADR_WDG, (40 << 1) | 1);
		repeat (5) begin
			repeat (18) begin
				@(negedge CLK_I);
				fired |= watch_dog;
			end
			wb_write(ADR_WDG, (40 << 1) | 1); // refresh, about every 20 cycles
		end
		check_true("watch_dog rose while refreshed", !fired);
		waited = 0;
		while (!watch_dog && waited < 60) begin
			@(negedge CLK_I);
			waited++;
		end
		if (!watch_dog) begin
			$display("timeout: watch_dog did not rise after refreshing stopped");
			err_cnt++;
		end
		wb_write(ADR_WDG, 0);
		fired = 1'b0;
		repeat (100) begin
			@(negedge CLK_I);
			fired |= watch_dog;
		end
		check_true("watch_dog rose while disabled", !fired);
		end_test("watchdog", e0);
	endtask

	task automatic test_shift(input int c);
		int               e0, bits0, stcp0, mr0;
		logic [ADR_W-1:0] adr;
		logic [7:0]       data;
		logic [31:0]      rd;
		e0    = err_cnt;
		adr   = (c == 0) ? ADR_SFT : ADR_SFTB;
		data  = 8'($urandom);
		bits0 = bit_cnt[c];
		stcp0 = stcp_cnt[c];
		mr0   = mr_cnt[c];
		run_shift_cmd(adr, 32'(SFT_RESET));
		run_shift_cmd(adr, (32'(data) << 8) | 32'(SFT_SHIFT));
		run_shift_cmd(adr, 32'(SFT_LATCH));
		check_eq("shcp rising edges", bit_cnt[c] - bits0, 8);
		check_eq("shifted byte", bits_seen[c], data);
		check_eq("stcp pulses", stcp_cnt[c] - stcp0, 1);
		check_eq("mr_n low pulses", mr_cnt[c] - mr0, 1);
		for (int oe = 1; oe >= 0; oe--) begin
			run_shift_cmd(adr, (oe << 2) | 32'(SFT_OE));
			check_eq("oe_n pin", oe_n[c], !oe);
			wb_read(adr, rd);
			check_eq("oe_n status bit", rd[2], !oe);
		end
		end_test(c == 0 ? "shift chain a" : "shift chain b", e0);
	endtask

	task automatic test_fans();
		int          e0;
		logic [31:0] rd;
		e0 = err_cnt;
		@(posedge CLK_I);
		fan_run = 1'b1;
		repeat (3 * TICKS) @(negedge CLK_I);  // three full windows
		wb_read(ADR_FAN0, rd);
		check_true($sformatf("fan0 count %0d outside 19..21", rd), rd >= 19 && rd <= 21);
		wb_read(ADR_FAN1, rd);
		check_true($sformatf("fan1 count %0d outside 7..9", rd), rd >= 7 && rd <= 9);
		fan_run = 1'b0;
		end_test("fan tachometers", e0);
	endtask

	task automatic test_timers();
		int          e0, waited;
		logic [31:0] rd;
		logic        int_seen;
		e0 = err_cnt;
		wb_write(ADR_TIME, 32'h0002_0009);  // timer0 2 s unmasked, timer1 masked
		waited = 0;
		while (!time0_int && waited < 3 * TICKS) begin
			@(negedge CLK_I);
			waited++;
		end
		if (!time0_int) begin
			$display("timeout: time0_int did not rise within three seconds");
			err_cnt++;
		end
		wb_read(ADR_TIME, rd);
		check_eq("timer0 done bit", rd[8], 1);
		wb_write(ADR_TIME, 32'h0002_0100);  // clear timer0 done
		check_eq("time0_int after clear", time0_int, 0);
		wb_read(ADR_TIME, rd);
		check_eq("timer0 done bit after clear", rd[8], 0);
		wb_write(ADR_TIME, 32'h000b_0002);  // timer1 2 s, masked
		int_seen = 1'b0;
		waited   = 0;
		rd       = '0;
		while (!rd[24] && waited < 3 * TICKS) begin
			wb_read(ADR_TIME, rd);
			int_seen |= time1_int;
			waited++;
		end
		check_eq("timer1 done bit", rd[24], 1);
		check_true("time1_int rose while masked", !int_seen && !time1_int);
		end_test("timers", e0);
	endtask

	initial begin
		void'($urandom(32'hc735_ad00));
		RST_I    = 1'b1;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_i = '0;
		fan_in0  = 1'b0;
		fan_in1  = 1'b0;
		gpio_in  = 16'($urandom);
		repeat (10) @(negedge CLK_I);
		RST_I = 1'b0;
		test_reset_regs();
		test_pwm();
		test_watchdog();
		test_shift(0);
		test_shift(1);
		test_fans();
		test_timers();
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
			test_cnt, check_cnt, err_cnt, u_periph_top.u_assert.fail_cnt);
		if (err_cnt == 0 && u_periph_top.u_assert.fail_cnt == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
